// ==== common/tcdm_pkg.sv ====
package tcdm_pkg;

  // ******************************************************************
  // bus widths seen by every master
  // ******************************************************************
  localparam int unsigned DataWidth    = 32;
  localparam int unsigned AddrWidth    = 32;
  localparam int unsigned BeWidth      = DataWidth / 8;
  // byte select bits below the word address
  localparam int unsigned ByteOffWidth = 2;

  // ******************************************************************
  // atomic operation field
  // ******************************************************************
  localparam int unsigned AtopWidth = 6;

  // masters drive the raw code, the bank side decodes the split view
  typedef union packed {
    logic [AtopWidth-1:0] raw;
    struct packed {
      // set for any atomic, clear for a plain load or store
      logic       is_amo;
      // riscv funct5 of the amo instruction
      logic [4:0] func;
    } amo;
  } atop_t;

endpackage

// ==== common/amo_pkg.sv ====
package amo_pkg;

  // ******************************************************************
  // riscv funct5 codes carried in the atop field
  // ******************************************************************
  localparam logic [4:0] AmoAdd  = 5'b00000;
  localparam logic [4:0] AmoSwap = 5'b00001;
  localparam logic [4:0] AmoLr   = 5'b00010;
  localparam logic [4:0] AmoSc   = 5'b00011;
  localparam logic [4:0] AmoXor  = 5'b00100;
  localparam logic [4:0] AmoOr   = 5'b01000;
  localparam logic [4:0] AmoAnd  = 5'b01100;
  localparam logic [4:0] AmoMin  = 5'b10000;
  localparam logic [4:0] AmoMax  = 5'b10100;
  localparam logic [4:0] AmoMinu = 5'b11000;
  localparam logic [4:0] AmoMaxu = 5'b11100;

  // ******************************************************************
  // internal operation of the per-bank shim
  // ******************************************************************
  localparam int unsigned AmoOpWidth = 4;

  // none means a plain access, no write-back phase
  localparam logic [AmoOpWidth-1:0] AmoOpNone = 4'h0;
  localparam logic [AmoOpWidth-1:0] AmoOpSwap = 4'h1;
  localparam logic [AmoOpWidth-1:0] AmoOpAdd  = 4'h2;
  localparam logic [AmoOpWidth-1:0] AmoOpAnd  = 4'h3;
  localparam logic [AmoOpWidth-1:0] AmoOpOr   = 4'h4;
  localparam logic [AmoOpWidth-1:0] AmoOpXor  = 4'h5;
  localparam logic [AmoOpWidth-1:0] AmoOpMax  = 4'h6;
  localparam logic [AmoOpWidth-1:0] AmoOpMaxu = 4'h7;
  localparam logic [AmoOpWidth-1:0] AmoOpMin  = 4'h8;
  localparam logic [AmoOpWidth-1:0] AmoOpMinu = 4'h9;

endpackage

// ==== interconnect/bank_arbiter.sv ====
`timescale 1ns/1ps

module bank_arbiter #(
  parameter int unsigned NumMasters = 4
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic [NumMasters-1:0] req_i,
  input  logic                  ready_i,
  output logic [NumMasters-1:0] gnt_o
);

  localparam int unsigned PtrWidth = (NumMasters > 1) ? $clog2(NumMasters) : 1;

  logic [PtrWidth-1:0] ptr_q;
  logic [PtrWidth-1:0] ptr_next;
  logic [PtrWidth-1:0] winner;

  // search starts at the pointer and wraps around
  always_comb begin
    int unsigned idx;
    logic        found;
    gnt_o  = '0;
    winner = ptr_q;
    found  = 1'b0;
    for (int unsigned i = 0; i < NumMasters; i++) begin
      idx = (ptr_q + i) % NumMasters;
      if (req_i[idx] && !found) begin
        found  = 1'b1;
        winner = PtrWidth'(idx);
      end
    end
    // a busy shim blocks every grant on this bank
    if (found && ready_i) begin
      gnt_o[winner] = 1'b1;
    end
  end

  assign ptr_next = (winner == PtrWidth'(NumMasters - 1)) ? '0 : winner + 1'b1;

  // last winner gets lowest priority next time
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ptr_q <= '0;
    end else if (|gnt_o) begin
      ptr_q <= ptr_next;
    end
  end

endmodule

// ==== interconnect/tcdm_xbar.sv ====
`timescale 1ns/1ps

module tcdm_xbar #(
  parameter int unsigned NumMasters = 4,
  parameter int unsigned NumBanks   = 4,
  parameter int unsigned RowWidth   = 8
) (
  input  logic                                              clk_i,
  input  logic                                              rst_ni,
  // master side
  input  logic [NumMasters-1:0]                             req_i,
  input  logic [NumMasters-1:0]                             we_i,
  input  logic [NumMasters-1:0][tcdm_pkg::AddrWidth-1:0]    addr_i,
  input  logic [NumMasters-1:0][tcdm_pkg::DataWidth-1:0]    wdata_i,
  input  logic [NumMasters-1:0][tcdm_pkg::BeWidth-1:0]      be_i,
  input  tcdm_pkg::atop_t [NumMasters-1:0]                  atop_i,
  output logic [NumMasters-1:0]                             gnt_o,
  output logic [NumMasters-1:0]                             r_valid_o,
  output logic [NumMasters-1:0][tcdm_pkg::DataWidth-1:0]    r_rdata_o,
  // bank side, toward the atomic shims
  output logic [NumBanks-1:0]                               bank_req_o,
  output logic [NumBanks-1:0]                               bank_we_o,
  output logic [NumBanks-1:0][RowWidth-1:0]                 bank_row_o,
  output logic [NumBanks-1:0][tcdm_pkg::DataWidth-1:0]      bank_wdata_o,
  output logic [NumBanks-1:0][tcdm_pkg::BeWidth-1:0]        bank_be_o,
  output tcdm_pkg::atop_t [NumBanks-1:0]                    bank_atop_o,
  input  logic [NumBanks-1:0]                               bank_ready_i,
  input  logic [NumBanks-1:0][tcdm_pkg::DataWidth-1:0]      bank_rdata_i
);

  localparam int unsigned BankSelWidth = $clog2(NumBanks);

  logic [NumMasters-1:0][BankSelWidth-1:0] master_bank;
  logic [NumMasters-1:0][RowWidth-1:0]     master_row;
  logic [NumBanks-1:0][NumMasters-1:0]     bank_reqs;
  logic [NumBanks-1:0][NumMasters-1:0]     bank_gnt;
  logic [NumMasters-1:0]                   resp_valid_q;
  logic [NumMasters-1:0][BankSelWidth-1:0] resp_bank_q;

  // ******************************************************************
  // address decode, word interleaved over the banks
  // ******************************************************************
  always_comb begin
    for (int m = 0; m < NumMasters; m++) begin
      master_bank[m] = addr_i[m][tcdm_pkg::ByteOffWidth +: BankSelWidth];
      master_row[m]  = addr_i[m][tcdm_pkg::ByteOffWidth + BankSelWidth +: RowWidth];
    end
  end

  always_comb begin
    for (int b = 0; b < NumBanks; b++) begin
      for (int m = 0; m < NumMasters; m++) begin
        bank_reqs[b][m] = req_i[m] && (master_bank[m] == BankSelWidth'(b));
      end
    end
  end

  for (genvar b = 0; b < NumBanks; b++) begin : gen_arb
    bank_arbiter #(
      .NumMasters ( NumMasters )
    ) i_bank_arbiter (
      .clk_i,
      .rst_ni,
      .req_i   ( bank_reqs[b]    ),
      .ready_i ( bank_ready_i[b] ),
      .gnt_o   ( bank_gnt[b]     )
    );
  end

  // a master targets one bank, so at most one arbiter grants it
  always_comb begin
    gnt_o = '0;
    for (int b = 0; b < NumBanks; b++) begin
      gnt_o = gnt_o | bank_gnt[b];
    end
  end

  // ******************************************************************
  // forward the winning master's fields to each bank
  // ******************************************************************
  always_comb begin
    bank_req_o   = '0;
    bank_we_o    = '0;
    bank_row_o   = '0;
    bank_wdata_o = '0;
    bank_be_o    = '0;
    bank_atop_o  = '0;
    for (int b = 0; b < NumBanks; b++) begin
      for (int m = 0; m < NumMasters; m++) begin
        if (bank_gnt[b][m]) begin
          bank_req_o[b]   = 1'b1;
          bank_we_o[b]    = we_i[m];
          bank_row_o[b]   = master_row[m];
          bank_wdata_o[b] = wdata_i[m];
          bank_be_o[b]    = be_i[m];
          bank_atop_o[b]  = atop_i[m];
        end
      end
    end
  end

  // ******************************************************************
  // response path, fixed latency of one cycle
  // ******************************************************************
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      resp_valid_q <= '0;
    end else begin
      resp_valid_q <= gnt_o;
    end
  end

  // remember which bank will answer
  always_ff @(posedge clk_i) begin
    for (int m = 0; m < NumMasters; m++) begin
      if (gnt_o[m]) begin
        resp_bank_q[m] <= master_bank[m];
      end
    end
  end

  assign r_valid_o = resp_valid_q;

  always_comb begin
    for (int m = 0; m < NumMasters; m++) begin
      r_rdata_o[m] = bank_rdata_i[resp_bank_q[m]];
    end
  end

endmodule

// ==== logic/amo_shim.sv ====
`timescale 1ns/1ps

module amo_shim #(
  parameter int unsigned RowWidth = 8
) (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  // from the crossbar
  input  logic                           req_i,
  input  logic                           we_i,
  input  logic [RowWidth-1:0]            row_i,
  input  logic [tcdm_pkg::DataWidth-1:0] wdata_i,
  input  logic [tcdm_pkg::BeWidth-1:0]   be_i,
  input  tcdm_pkg::atop_t                atop_i,
  output logic                           ready_o,
  output logic [tcdm_pkg::DataWidth-1:0] rdata_o,
  // to the memory bank
  output logic                           mem_req_o,
  output logic                           mem_we_o,
  output logic [RowWidth-1:0]            mem_row_o,
  output logic [tcdm_pkg::DataWidth-1:0] mem_wdata_o,
  output logic [tcdm_pkg::BeWidth-1:0]   mem_be_o,
  input  logic [tcdm_pkg::DataWidth-1:0] mem_rdata_i
);

  logic [amo_pkg::AmoOpWidth-1:0] amo_op;
  logic [amo_pkg::AmoOpWidth-1:0] op_q;
  logic [tcdm_pkg::DataWidth-1:0] operand_q;
  logic [RowWidth-1:0]            row_q;
  logic [tcdm_pkg::DataWidth-1:0] amo_result;
  logic                           amo_start;
  logic                           wr_phase_q;

  // ******************************************************************
  // atop decode
  // ******************************************************************
  always_comb begin
    amo_op = amo_pkg::AmoOpNone;
    if (atop_i.amo.is_amo) begin
      case (atop_i.amo.func)
        amo_pkg::AmoAdd:  amo_op = amo_pkg::AmoOpAdd;
        amo_pkg::AmoSwap: amo_op = amo_pkg::AmoOpSwap;
        amo_pkg::AmoXor:  amo_op = amo_pkg::AmoOpXor;
        amo_pkg::AmoOr:   amo_op = amo_pkg::AmoOpOr;
        amo_pkg::AmoAnd:  amo_op = amo_pkg::AmoOpAnd;
        amo_pkg::AmoMin:  amo_op = amo_pkg::AmoOpMin;
        amo_pkg::AmoMax:  amo_op = amo_pkg::AmoOpMax;
        amo_pkg::AmoMinu: amo_op = amo_pkg::AmoOpMinu;
        amo_pkg::AmoMaxu: amo_op = amo_pkg::AmoOpMaxu;
        // no reservation station here, LR and SC just read
        amo_pkg::AmoLr,
        amo_pkg::AmoSc:   amo_op = amo_pkg::AmoOpNone;
        default:          amo_op = amo_pkg::AmoOpNone;
      endcase
    end
  end

  assign amo_start = req_i && !wr_phase_q && (amo_op != amo_pkg::AmoOpNone);

  // ******************************************************************
  // read-modify-write sequencing
  // ******************************************************************
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_phase_q <= 1'b0;
    end else begin
      wr_phase_q <= amo_start;
    end
  end

  always_ff @(posedge clk_i) begin
    if (amo_start) begin
      op_q      <= amo_op;
      operand_q <= wdata_i;
      row_q     <= row_i;
    end
  end

  // old value arrives from the bank in the write phase
  always_comb begin
    case (op_q)
      amo_pkg::AmoOpSwap: amo_result = operand_q;
      amo_pkg::AmoOpAdd:  amo_result = mem_rdata_i + operand_q;
      amo_pkg::AmoOpAnd:  amo_result = mem_rdata_i & operand_q;
      amo_pkg::AmoOpOr:   amo_result = mem_rdata_i | operand_q;
      amo_pkg::AmoOpXor:  amo_result = mem_rdata_i ^ operand_q;
      amo_pkg::AmoOpMax: begin
        amo_result = ($signed(mem_rdata_i) > $signed(operand_q)) ? mem_rdata_i : operand_q;
      end
      amo_pkg::AmoOpMin: begin
        amo_result = ($signed(mem_rdata_i) < $signed(operand_q)) ? mem_rdata_i : operand_q;
      end
      amo_pkg::AmoOpMaxu: amo_result = (mem_rdata_i > operand_q) ? mem_rdata_i : operand_q;
      amo_pkg::AmoOpMinu: amo_result = (mem_rdata_i < operand_q) ? mem_rdata_i : operand_q;
      default:            amo_result = mem_rdata_i;
    endcase
  end

  // ******************************************************************
  // memory port
  // ******************************************************************
  always_comb begin
    if (wr_phase_q) begin
      mem_req_o   = 1'b1;
      mem_we_o    = 1'b1;
      mem_row_o   = row_q;
      mem_wdata_o = amo_result;
      mem_be_o    = '1;
    end else begin
      mem_req_o   = req_i;
      // every atomic code reads first, whatever we_i says
      mem_we_o    = we_i && !atop_i.amo.is_amo;
      mem_row_o   = row_i;
      mem_wdata_o = wdata_i;
      mem_be_o    = be_i;
    end
  end

  // bank is busy while the write-back goes out
  assign ready_o = !wr_phase_q;
  assign rdata_o = mem_rdata_i;

endmodule

// ==== logic/tcdm_bank.sv ====
`timescale 1ns/1ps

module tcdm_bank #(
  parameter int unsigned RowWidth = 8
) (
  input  logic                           clk_i,
  input  logic                           mem_req_i,
  input  logic                           mem_we_i,
  input  logic [RowWidth-1:0]            mem_row_i,
  input  logic [tcdm_pkg::DataWidth-1:0] mem_wdata_i,
  input  logic [tcdm_pkg::BeWidth-1:0]   mem_be_i,
  output logic [tcdm_pkg::DataWidth-1:0] mem_rdata_o
);

  localparam int unsigned NumRows = 2 ** RowWidth;

  logic [tcdm_pkg::DataWidth-1:0] mem_q [NumRows];
  logic [tcdm_pkg::DataWidth-1:0] rdata_q;

  // read data only changes on a read, writes leave it alone
  always_ff @(posedge clk_i) begin
    if (mem_req_i) begin
      if (mem_we_i) begin
        for (int i = 0; i < tcdm_pkg::BeWidth; i++) begin
          if (mem_be_i[i]) begin
            mem_q[mem_row_i][i*8 +: 8] <= mem_wdata_i[i*8 +: 8];
          end
        end
      end else begin
        rdata_q <= mem_q[mem_row_i];
      end
    end
  end

  assign mem_rdata_o = rdata_q;

endmodule

// ==== logic/tcdm_cluster_top.sv ====
`timescale 1ns/1ps

module tcdm_cluster_top #(
  parameter int unsigned NumMasters = 4,
  parameter int unsigned NumBanks   = 4,
  parameter int unsigned RowWidth   = 8
) (
  input  logic                                           clk_i,
  input  logic                                           rst_ni,
  input  logic [NumMasters-1:0]                          req_i,
  input  logic [NumMasters-1:0]                          we_i,
  input  logic [NumMasters-1:0][tcdm_pkg::AddrWidth-1:0] addr_i,
  input  logic [NumMasters-1:0][tcdm_pkg::DataWidth-1:0] wdata_i,
  input  logic [NumMasters-1:0][tcdm_pkg::BeWidth-1:0]   be_i,
  input  tcdm_pkg::atop_t [NumMasters-1:0]               atop_i,
  output logic [NumMasters-1:0]                          gnt_o,
  output logic [NumMasters-1:0]                          r_valid_o,
  output logic [NumMasters-1:0][tcdm_pkg::DataWidth-1:0] r_rdata_o
);

  // crossbar to shims
  logic [NumBanks-1:0]                          bank_req;
  logic [NumBanks-1:0]                          bank_we;
  logic [NumBanks-1:0][RowWidth-1:0]            bank_row;
  logic [NumBanks-1:0][tcdm_pkg::DataWidth-1:0] bank_wdata;
  logic [NumBanks-1:0][tcdm_pkg::BeWidth-1:0]   bank_be;
  tcdm_pkg::atop_t [NumBanks-1:0]               bank_atop;
  logic [NumBanks-1:0]                          bank_ready;
  logic [NumBanks-1:0][tcdm_pkg::DataWidth-1:0] bank_rdata;

  // shims to memories
  logic [NumBanks-1:0]                          mem_req;
  logic [NumBanks-1:0]                          mem_we;
  logic [NumBanks-1:0][RowWidth-1:0]            mem_row;
  logic [NumBanks-1:0][tcdm_pkg::DataWidth-1:0] mem_wdata;
  logic [NumBanks-1:0][tcdm_pkg::BeWidth-1:0]   mem_be;
  logic [NumBanks-1:0][tcdm_pkg::DataWidth-1:0] mem_rdata;

  tcdm_xbar #(
    .NumMasters ( NumMasters ),
    .NumBanks   ( NumBanks   ),
    .RowWidth   ( RowWidth   )
  ) i_tcdm_xbar (
    .clk_i,
    .rst_ni,
    .req_i,
    .we_i,
    .addr_i,
    .wdata_i,
    .be_i,
    .atop_i,
    .gnt_o,
    .r_valid_o,
    .r_rdata_o,
    .bank_req_o   ( bank_req   ),
    .bank_we_o    ( bank_we    ),
    .bank_row_o   ( bank_row   ),
    .bank_wdata_o ( bank_wdata ),
    .bank_be_o    ( bank_be    ),
    .bank_atop_o  ( bank_atop  ),
    .bank_ready_i ( bank_ready ),
    .bank_rdata_i ( bank_rdata )
  );

  // ******************************************************************
  // one shim and one memory per bank
  // ******************************************************************
  for (genvar b = 0; b < NumBanks; b++) begin : gen_bank
    amo_shim #(
      .RowWidth ( RowWidth )
    ) i_amo_shim (
      .clk_i,
      .rst_ni,
      .req_i       ( bank_req[b]   ),
      .we_i        ( bank_we[b]    ),
      .row_i       ( bank_row[b]   ),
      .wdata_i     ( bank_wdata[b] ),
      .be_i        ( bank_be[b]    ),
      .atop_i      ( bank_atop[b]  ),
      .ready_o     ( bank_ready[b] ),
      .rdata_o     ( bank_rdata[b] ),
      .mem_req_o   ( mem_req[b]    ),
      .mem_we_o    ( mem_we[b]     ),
      .mem_row_o   ( mem_row[b]    ),
      .mem_wdata_o ( mem_wdata[b]  ),
      .mem_be_o    ( mem_be[b]     ),
      .mem_rdata_i ( mem_rdata[b]  )
    );

    tcdm_bank #(
      .RowWidth ( RowWidth )
    ) i_tcdm_bank (
      .clk_i,
      .mem_req_i   ( mem_req[b]   ),
      .mem_we_i    ( mem_we[b]    ),
      .mem_row_i   ( mem_row[b]   ),
      .mem_wdata_i ( mem_wdata[b] ),
      .mem_be_i    ( mem_be[b]    ),
      .mem_rdata_o ( mem_rdata[b] )
    );
  end

endmodule

// ==== verification/tcdm_cluster_assert.sv ====
`timescale 1ns/1ps

module tcdm_cluster_assert #(
  parameter int unsigned NumMasters = 4,
  parameter int unsigned NumBanks   = 4
) (
  input logic                                clk_i,
  input logic                                rst_ni,
  input logic [NumMasters-1:0]               req_i,
  input logic [NumMasters-1:0]               gnt_i,
  input logic [NumMasters-1:0]               r_valid_i,
  input logic [NumBanks-1:0][NumMasters-1:0] bank_gnt_i
);

  // a grant never shows up without its request
  gnt_needs_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (gnt_i & ~req_i) == '0)
    else $error("grant without a matching request");

  for (genvar b = 0; b < NumBanks; b++) begin : gen_bank_chk
    one_gnt_per_bank: assert property (@(posedge clk_i) disable iff (!rst_ni)
      $onehot0(bank_gnt_i[b]))
      else $error("more than one master granted on bank %0d", b);
  end

  // fixed one cycle response latency
  for (genvar m = 0; m < NumMasters; m++) begin : gen_resp_chk
    resp_after_gnt: assert property (@(posedge clk_i) disable iff (!rst_ni)
      gnt_i[m] |=> r_valid_i[m])
      else $error("no response one cycle after grant on master %0d", m);
  end

endmodule

bind tcdm_xbar tcdm_cluster_assert #(
  .NumMasters ( NumMasters ),
  .NumBanks   ( NumBanks   )
) i_tcdm_cluster_assert (
  .clk_i,
  .rst_ni,
  .req_i,
  .gnt_i      ( gnt_o     ),
  .r_valid_i  ( r_valid_o ),
  .bank_gnt_i ( bank_gnt  )
);

// ==== verification/tb_tcdm_cluster.sv ====
`timescale 1ns/1ps

module tb_tcdm_cluster;

  localparam int unsigned NumMasters = 4;
  localparam int unsigned NumBanks   = 4;
  localparam int unsigned RowWidth   = 8;
  localparam int unsigned IdxWidth   = $clog2(NumBanks) + RowWidth;
  localparam int unsigned Seed       = 55;
  localparam int unsigned Timeout    = 50;

  localparam logic [4:0] AmoFuncs [9] = '{
    amo_pkg::AmoAdd, amo_pkg::AmoSwap, amo_pkg::AmoXor, amo_pkg::AmoOr, amo_pkg::AmoAnd,
    amo_pkg::AmoMin, amo_pkg::AmoMax, amo_pkg::AmoMinu, amo_pkg::AmoMaxu
  };

  logic                                           clk_i;
  logic                                           rst_ni;
  logic [NumMasters-1:0]                          req;
  logic [NumMasters-1:0]                          we;
  logic [NumMasters-1:0][tcdm_pkg::AddrWidth-1:0] addr;
  logic [NumMasters-1:0][tcdm_pkg::DataWidth-1:0] wdata;
  logic [NumMasters-1:0][tcdm_pkg::BeWidth-1:0]   be;
  tcdm_pkg::atop_t [NumMasters-1:0]               atop;
  logic [NumMasters-1:0]                          gnt;
  logic [NumMasters-1:0]                          r_valid;
  logic [NumMasters-1:0][tcdm_pkg::DataWidth-1:0] r_rdata;

  // reference memory indexed by bank and row together
  logic [tcdm_pkg::DataWidth-1:0] ref_mem [2**IdxWidth];

  tcdm_cluster_top uut (
    .clk_i,
    .rst_ni,
    .req_i     ( req     ),
    .we_i      ( we      ),
    .addr_i    ( addr    ),
    .wdata_i   ( wdata   ),
    .be_i      ( be      ),
    .atop_i    ( atop    ),
    .gnt_o     ( gnt     ),
    .r_valid_o ( r_valid ),
    .r_rdata_o ( r_rdata )
  );

  always #10 clk_i = ~clk_i;

  // **********************************************************************
  // checks and reference model
  // **********************************************************************
  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_data(input string name, input logic [tcdm_pkg::DataWidth-1:0] got,
                            input logic [tcdm_pkg::DataWidth-1:0] exp);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
      report_failure("data check failed");
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s is %b, expected %b", $time, name, got, exp);
      report_failure("flag check failed");
    end
  endtask

  function automatic int unsigned word_index(input logic [tcdm_pkg::AddrWidth-1:0] a);
    return int'(a[tcdm_pkg::ByteOffWidth +: IdxWidth]);
  endfunction

  task automatic model_write(input logic [tcdm_pkg::AddrWidth-1:0] a,
                             input logic [tcdm_pkg::DataWidth-1:0] d,
                             input logic [tcdm_pkg::BeWidth-1:0] b);
    int unsigned idx;
    idx = word_index(a);
    for (int i = 0; i < tcdm_pkg::BeWidth; i++) begin
      if (b[i]) begin
        ref_mem[idx][i*8 +: 8] = d[i*8 +: 8];
      end
    end
  endtask

  // new memory word as the riscv amo instructions define it
  function automatic logic [tcdm_pkg::DataWidth-1:0] amo_expect(
    input logic [4:0] func, input logic [tcdm_pkg::DataWidth-1:0] old_val,
    input logic [tcdm_pkg::DataWidth-1:0] operand);
    case (func)
      amo_pkg::AmoAdd:  return old_val + operand;
      amo_pkg::AmoSwap: return operand;
      amo_pkg::AmoXor:  return old_val ^ operand;
      amo_pkg::AmoOr:   return old_val | operand;
      amo_pkg::AmoAnd:  return old_val & operand;
      amo_pkg::AmoMin:  return ($signed(old_val) < $signed(operand)) ? old_val : operand;
      amo_pkg::AmoMax:  return ($signed(old_val) > $signed(operand)) ? old_val : operand;
      amo_pkg::AmoMinu: return (old_val < operand) ? old_val : operand;
      amo_pkg::AmoMaxu: return (old_val > operand) ? old_val : operand;
      default:          return old_val;
    endcase
  endfunction

  // **********************************************************************
  // master side driving
  // **********************************************************************
  task automatic drive_request(input int m, input logic w,
                               input logic [tcdm_pkg::AddrWidth-1:0] a,
                               input logic [tcdm_pkg::DataWidth-1:0] d,
                               input logic [tcdm_pkg::BeWidth-1:0] b,
                               input logic [tcdm_pkg::AtopWidth-1:0] op);
    req[m]      = 1'b1;
    we[m]       = w;
    addr[m]     = a;
    wdata[m]    = d;
    be[m]       = b;
    atop[m].raw = op;
  endtask

  // returns at the falling edge of the cycle that carries the grant
  task automatic wait_grant(input int m);
    int unsigned cycles;
    cycles = 0;
    @(negedge clk_i);
    while (!gnt[m]) begin
      cycles++;
      if (cycles >= Timeout) begin
        report_failure($sformatf("no grant from master %0d within timeout", m));
      end
      @(negedge clk_i);
    end
  endtask

  task automatic access(input int m, input logic w, input logic [tcdm_pkg::AddrWidth-1:0] a,
                        input logic [tcdm_pkg::DataWidth-1:0] d,
                        input logic [tcdm_pkg::BeWidth-1:0] b,
                        input logic [tcdm_pkg::AtopWidth-1:0] op,
                        output logic [tcdm_pkg::DataWidth-1:0] rdata);
    @(posedge clk_i);
    #2;
    drive_request(m, w, a, d, b, op);
    wait_grant(m);
    // the response must not appear before the granting edge
    check_flag($sformatf("r_valid_o[%0d]", m), r_valid[m], 1'b0);
    @(posedge clk_i);
    #2;
    req[m] = 1'b0;
    @(negedge clk_i);
    check_flag($sformatf("r_valid_o[%0d]", m), r_valid[m], 1'b1);
    rdata = r_rdata[m];
  endtask

  task automatic write_word(input int m, input logic [tcdm_pkg::AddrWidth-1:0] a,
                            input logic [tcdm_pkg::DataWidth-1:0] d,
                            input logic [tcdm_pkg::BeWidth-1:0] b);
    logic [tcdm_pkg::DataWidth-1:0] unused;
    access(m, 1'b1, a, d, b, '0, unused);
    model_write(a, d, b);
  endtask

  task automatic read_check(input int m, input logic [tcdm_pkg::AddrWidth-1:0] a);
    logic [tcdm_pkg::DataWidth-1:0] rdata;
    access(m, 1'b0, a, '0, '0, '0, rdata);
    check_data($sformatf("r_rdata_o[%0d] at %h", m, a), rdata, ref_mem[word_index(a)]);
  endtask

  task automatic amo_check(input int m, input logic [4:0] func,
                           input logic [tcdm_pkg::AddrWidth-1:0] a,
                           input logic [tcdm_pkg::DataWidth-1:0] operand);
    logic [tcdm_pkg::DataWidth-1:0] rdata;
    int unsigned                    idx;
    idx = word_index(a);
    access(m, 1'b1, a, operand, '1, {1'b1, func}, rdata);
    // response carries the value before the update
    check_data($sformatf("r_rdata_o[%0d] amo old value", m), rdata, ref_mem[idx]);
    ref_mem[idx] = amo_expect(func, ref_mem[idx], operand);
  endtask

  // **********************************************************************
  // directed tests
  // **********************************************************************
  task automatic test_write_read();
    // 16 consecutive words walk over every bank
    for (int i = 0; i < 16; i++) begin
      write_word(0, 32'(i * 4), $urandom, '1);
    end
    for (int i = 0; i < 16; i++) begin
      read_check(0, 32'(i * 4));
    end
  endtask

  task automatic test_byte_enables();
    write_word(1, 32'h0000_0104, $urandom, 4'b1111);
    write_word(1, 32'h0000_0104, $urandom, 4'b0101);
    read_check(2, 32'h0000_0104);
    write_word(3, 32'h0000_0104, $urandom, 4'b1000);
    read_check(1, 32'h0000_0104);
  endtask

  task automatic test_conflict();
    logic [NumMasters-1:0]          pending;
    logic [NumMasters-1:0]          granted;
    logic [tcdm_pkg::AddrWidth-1:0] waddr [NumMasters];
    logic [tcdm_pkg::DataWidth-1:0] wval [NumMasters];
    int unsigned                    cycles;
    @(posedge clk_i);
    #2;
    // every master hits bank 1 on a row of its own
    for (int m = 0; m < NumMasters; m++) begin
      waddr[m] = 32'(((8 + m) * NumBanks + 1) * 4);
      wval[m]  = 32'hc0de_0000 + 32'(m);
      drive_request(m, 1'b1, waddr[m], wval[m], '1, '0);
    end
    pending = '1;
    cycles  = 0;
    while (pending != '0) begin
      if (cycles >= NumMasters) begin
        report_failure("not every master granted within NumMasters cycles on one bank");
      end
      @(negedge clk_i);
      check_flag("gnt_o one-hot", $onehot(gnt), 1'b1);
      granted = gnt;
      @(posedge clk_i);
      #2;
      for (int m = 0; m < NumMasters; m++) begin
        if (granted[m]) begin
          req[m] = 1'b0;
          model_write(waddr[m], wval[m], '1);
        end
      end
      pending = pending & ~granted;
      cycles++;
    end
    for (int m = 0; m < NumMasters; m++) begin
      read_check(0, waddr[m]);
    end
  endtask

  task automatic test_parallel();
    logic [tcdm_pkg::DataWidth-1:0] wval [NumMasters];
    @(posedge clk_i);
    #2;
    // master m goes to bank m
    for (int m = 0; m < NumMasters; m++) begin
      wval[m] = $urandom;
      drive_request(m, 1'b1, 32'(32'h300 + m * 4), wval[m], '1, '0);
    end
    @(negedge clk_i);
    for (int m = 0; m < NumMasters; m++) begin
      check_flag($sformatf("gnt_o[%0d]", m), gnt[m], 1'b1);
    end
    @(posedge clk_i);
    #2;
    for (int m = 0; m < NumMasters; m++) begin
      req[m] = 1'b0;
      model_write(32'(32'h300 + m * 4), wval[m], '1);
    end
    for (int m = 0; m < NumMasters; m++) begin
      read_check((m + 1) % NumMasters, 32'(32'h300 + m * 4));
    end
  endtask

  task automatic test_atomics();
    logic [tcdm_pkg::AddrWidth-1:0] a;
    logic [tcdm_pkg::DataWidth-1:0] init;
    logic [tcdm_pkg::DataWidth-1:0] operand;
    for (int k = 0; k < 9; k++) begin
      a       = 32'(32'h400 + k * 4);
      init    = $urandom;
      operand = $urandom;
      // signed compares see a negative old value and a random operand
      if (AmoFuncs[k] == amo_pkg::AmoMin || AmoFuncs[k] == amo_pkg::AmoMax) begin
        init[31] = 1'b1;
      end
      write_word(k % NumMasters, a, init, '1);
      amo_check(k % NumMasters, AmoFuncs[k], a, operand);
      read_check((k + 1) % NumMasters, a);
    end
  endtask

  task automatic test_amo_contention();
    logic [tcdm_pkg::AddrWidth-1:0] a;
    logic [tcdm_pkg::DataWidth-1:0] init;
    logic [tcdm_pkg::DataWidth-1:0] operand [2];
    logic [tcdm_pkg::DataWidth-1:0] rdata;
    logic [1:0]                     pending;
    logic [1:0]                     granted;
    logic [1:0]                     prev;
    int unsigned                    idx;
    int unsigned                    cycles;
    a    = 32'h0000_0520;
    idx  = word_index(a);
    init = $urandom;
    write_word(2, a, init, '1);
    operand[0] = $urandom;
    operand[1] = $urandom;
    @(posedge clk_i);
    #2;
    for (int i = 0; i < 2; i++) begin
      drive_request(i, 1'b1, a, operand[i], '1, {1'b1, amo_pkg::AmoAdd});
    end
    pending = 2'b11;
    prev    = 2'b00;
    cycles  = 0;
    while (pending != 2'b00 || prev != 2'b00) begin
      if (cycles >= Timeout) begin
        report_failure("contending atomic adds not served within timeout");
      end
      @(negedge clk_i);
      for (int i = 0; i < 2; i++) begin
        if (prev[i]) begin
          check_flag($sformatf("r_valid_o[%0d]", i), r_valid[i], 1'b1);
          check_data($sformatf("r_rdata_o[%0d] amo old value", i), r_rdata[i], ref_mem[idx]);
          ref_mem[idx] = ref_mem[idx] + operand[i];
        end
      end
      granted = gnt[1:0];
      check_flag("gnt_o[1:0] at most one", $onehot0(granted), 1'b1);
      @(posedge clk_i);
      #2;
      for (int i = 0; i < 2; i++) begin
        if (granted[i]) begin
          req[i] = 1'b0;
        end
      end
      pending = pending & ~granted;
      prev    = granted;
      cycles++;
    end
    access(3, 1'b0, a, '0, '0, '0, rdata);
    check_data("r_rdata_o[3] final sum", rdata, init + operand[0] + operand[1]);
  endtask

  // **********************************************************************
  // run
  // **********************************************************************
  initial begin
    void'($urandom(Seed));
    clk_i  = 1'b0;
    rst_ni = 1'b0;
    req    = '0;
    we     = '0;
    addr   = '0;
    wdata  = '0;
    be     = '0;
    atop   = '0;
    repeat (5) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;

    test_write_read();
    test_byte_enables();
    test_conflict();
    test_parallel();
    test_atomics();
    test_amo_contention();

    $display("TEST PASSED");
    $finish;
  end

endmodule

// ==== tb.f ====
common/tcdm_pkg.sv
common/amo_pkg.sv
interconnect/bank_arbiter.sv
interconnect/tcdm_xbar.sv
logic/amo_shim.sv
logic/tcdm_bank.sv
logic/tcdm_cluster_top.sv
verification/tcdm_cluster_assert.sv
verification/tb_tcdm_cluster.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := tb_tcdm_cluster
FILELIST   := tb.f
BUILD_DIR  := obj_dir
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -Wno-fatal
PASS_MSG   := TEST PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
